/* compile.f */
src/hatch_pkg.sv
src/input_decode.sv
src/tick_gen.sv
src/hatch_fsm.sv
src/seg_scan.sv
src/matrix_scan.sv
src/egg_hatch_top.sv
test/hatch_checker.sv
test/hatch_monitor.sv
test/tb_egg_hatch.sv

/* test/tb_egg_hatch.sv */
// testbench top: clock, reset, random games on btn0 and sw0, watchdog, final report
`timescale 1ns/1ns

module tb_egg_hatch;

    localparam int tick_cycles = 8;
    localparam int debounce_cycles = 3;
    localparam int scan_cycles = 2;
    localparam int clk_period = 100;
    localparam int games = 12;
    localparam int game_ticks = 40;
    localparam int max_slots = 40;
    localparam int kind_warm = 0;
    localparam int kind_cold = 1;

    logic clk;
    logic sw7;
    logic btn0;
    logic sw0;
    logic led0;
    logic led2;
    logic [7:0] row;
    logic [7:0] colg;
    logic [7:0] colr;
    logic [7:0] seg;
    logic [7:0] dig;
    logic [31:0] rng_state;
    int monitor_errors;
    int tb_errors;
    int assert_errors;
    int cyc;

    egg_hatch_top #(
        .TICK_CYCLES(tick_cycles),
        .DEBOUNCE_CYCLES(debounce_cycles),
        .SCAN_CYCLES(scan_cycles)
    ) i_egg_hatch_top (
        .clk (clk),
        .sw7 (sw7),
        .btn0(btn0),
        .sw0 (sw0),
        .led0(led0),
        .led2(led2),
        .row (row),
        .colg(colg),
        .colr(colr),
        .seg (seg),
        .dig (dig)
    );

    hatch_monitor #(
        .TICK_CYCLES(tick_cycles),
        .DEBOUNCE_CYCLES(debounce_cycles)
    ) i_hatch_monitor (
        .clk        (clk),
        .sw7        (sw7),
        .btn0       (btn0),
        .sw0        (sw0),
        .led0       (led0),
        .led2       (led2),
        .row        (row),
        .colr       (colr),
        .colg       (colg),
        .seg        (seg),
        .dig        (dig),
        .error_count(monitor_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // cycles since reset release, lines sw0 changes up with the tick period
    always @(posedge clk or negedge sw7)
    begin
        if (!sw7)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pick(input int range);
        rng_state = xorshift(rng_state);
        return int'(rng_state % 32'(range));
    endfunction

    task automatic next_drive_point();
        @(posedge clk);
        #10;
    endtask

    task automatic push_button();
        btn0 = 1'b1;
        repeat (6) next_drive_point();
        btn0 = 1'b0;
        repeat (6) next_drive_point();
    endtask

    // mid-period slot, so each level covers exactly one tick
    task automatic heat_slot(input logic level);
        do
            next_drive_point();
        while (cyc % tick_cycles != tick_cycles / 2);
        sw0 = level;
    endtask

    initial
    begin
        #((games * game_ticks * tick_cycles + 10) * clk_period);
        $display("watchdog: simulation ran past its time limit");
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin : stimulus
        int kind;
        int slot;
        int late_cold;
        int warm_lead;
        int cold_run;
        logic level;
        rng_state = 32'hd24d;
        tb_errors = 0;
        sw7 = 1'b0;
        btn0 = 1'b0;
        sw0 = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        sw7 = 1'b1;
        repeat (4) next_drive_point();
        for (int g = 0; g < games; g++)
        begin
            kind = pick(3);
            late_cold = pick(2);
            warm_lead = pick(8);
            cold_run = 1 + pick(4);
            sw0 = (kind == kind_cold) ? (warm_lead > 0) : 1'b1;
            push_button();
            slot = 0;
            while (!(led0 || led2) && slot < max_slots)
            begin
                slot++;
                case (kind)
                    kind_warm: level = !(late_cold != 0 && slot >= 24);
                    kind_cold: level = (slot <= warm_lead);
                    default: level = !(slot >= 3 && slot < 3 + cold_run);
                endcase
                heat_slot(level);
                // ignored while incubating
                if (kind == kind_warm && slot == 8)
                    push_button();
            end
            if (!(led0 || led2))
            begin
                tb_errors++;
                $display("game %0d reached no end stage within %0d ticks", g, max_slots);
            end
            push_button();
        end
        repeat (4) next_drive_point();
        assert_errors = i_egg_hatch_top.i_hatch_fsm.fsm_check.fail_count
            + i_egg_hatch_top.i_input_decode.decode_check.fail_count
            + i_egg_hatch_top.i_seg_scan.seg_check.fail_count
            + i_egg_hatch_top.i_matrix_scan.matrix_check.fail_count;
        $display("errors: monitor %0d, testbench %0d, assertions %0d",
            monitor_errors, tb_errors, assert_errors);
        if (monitor_errors + tb_errors + assert_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* test/hatch_monitor.sv */
// game reference model from the top ports, with led and digit comparison
`timescale 1ns/1ns

module hatch_monitor #(
    parameter int TICK_CYCLES = 8,
    parameter int DEBOUNCE_CYCLES = 3
) (
    input  logic       clk,
    input  logic       sw7,
    input  logic       btn0,
    input  logic       sw0,
    input  logic       led0,
    input  logic       led2,
    input  logic [7:0] row,
    input  logic [7:0] colr,
    input  logic [7:0] colg,
    input  logic [7:0] seg,
    input  logic [7:0] dig,
    output int         error_count
);

    import hatch_pkg::*;

    logic btn_s1;
    logic btn_s2;
    logic sw_s1;
    logic sw_s2;
    logic btn_accepted;
    logic press_m;
    logic tick_m;
    logic phase_m;
    int diff_run;
    int tick_run;
    int elapsed_m;
    int dev_m;
    int cold_m;
    // one cycle late copies, the digits are registered
    int elapsed_d;
    stage_t stage_m;
    stage_t stage_d;

    initial error_count = 0;

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        error_count = error_count + 1;
    endtask

    function automatic int decode_digit(input logic [7:0] pattern);
        for (int d = 0; d < 10; d++)
        begin
            if (seg_pattern(4'(d)) == pattern)
                return d;
        end
        return -1;
    endfunction

    task automatic check_digit(input int expected, input string place);
        int shown;
        shown = decode_digit(seg);
        if (shown != expected)
            report_mismatch($sformatf("%s digit shows %0d (seg %h), model expects %0d",
                place, shown, seg, expected));
    endtask

    always @(posedge clk or negedge sw7)
    begin : model_step
        int dev_next;
        int cold_next;
        if (!sw7)
        begin
            {btn_s1, btn_s2, sw_s1, sw_s2} <= 4'b0000;
            btn_accepted <= 1'b0;
            press_m <= 1'b0;
            tick_m <= 1'b0;
            phase_m <= 1'b0;
            diff_run <= 0;
            tick_run <= 0;
            elapsed_m <= 0;
            elapsed_d <= 0;
            dev_m <= 0;
            cold_m <= 0;
            stage_m <= st_ready;
            stage_d <= st_ready;
        end
        else
        begin
            btn_s1 <= btn0;
            btn_s2 <= btn_s1;
            sw_s1 <= sw0;
            sw_s2 <= sw_s1;
            // debounce: level taken after DEBOUNCE_CYCLES differing samples
            press_m <= 1'b0;
            if (btn_s2 == btn_accepted)
                diff_run <= 0;
            else if (diff_run + 1 == DEBOUNCE_CYCLES)
            begin
                diff_run <= 0;
                btn_accepted <= btn_s2;
                press_m <= btn_s2;
            end
            else
                diff_run <= diff_run + 1;
            tick_m <= (tick_run + 1 == TICK_CYCLES);
            tick_run <= (tick_run + 1 == TICK_CYCLES) ? 0 : tick_run + 1;
            stage_d <= stage_m;
            elapsed_d <= elapsed_m;
            case (stage_m)
                st_ready:
                begin
                    if (press_m)
                    begin
                        stage_m <= st_incubate;
                        elapsed_m <= 0;
                        dev_m <= 0;
                        cold_m <= 0;
                        phase_m <= 1'b0;
                    end
                end
                st_incubate, st_growing:
                begin
                    if (tick_m)
                    begin
                        dev_next = dev_m;
                        if (phase_m && (sw_s2 || stage_m == st_growing))
                            dev_next = dev_m + 1;
                        cold_next = sw_s2 ? 0 : cold_m + 1;
                        elapsed_m <= (elapsed_m < 99) ? elapsed_m + 1 : 99;
                        phase_m <= !phase_m;
                        dev_m <= dev_next;
                        if (stage_m == st_incubate)
                        begin
                            cold_m <= cold_next;
                            if (cold_next >= cold_limit)
                                stage_m <= st_failed;
                            else if (dev_next >= dev_grown)
                                stage_m <= st_growing;
                        end
                        else if (dev_next >= dev_hatched)
                            stage_m <= st_hatched;
                    end
                end
                default:
                begin
                    if (press_m)
                        stage_m <= st_ready;
                end
            endcase
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk)
    begin
        if (!sw7)
        begin
            if (led0 !== 1'b0 || led2 !== 1'b0 || dig !== 8'hff || row !== 8'hff
                || seg !== 8'hff || colr !== 8'hff || colg !== 8'hff)
                report_mismatch($sformatf(
                    "reset outputs led0 %b led2 %b dig %h row %h seg %h colr %h colg %h",
                    led0, led2, dig, row, seg, colr, colg));
        end
        else
        begin
            if (led0 !== (stage_m == st_hatched))
                report_mismatch($sformatf("led0 is %b in model stage %s", led0, stage_m.name()));
            if (led2 !== (stage_m == st_failed))
                report_mismatch($sformatf("led2 is %b in model stage %s", led2, stage_m.name()));
            if (stage_d == st_ready)
            begin
                if (dig !== 8'hff || seg !== 8'hff)
                    report_mismatch($sformatf("dig %h seg %h while waiting, expected blank",
                        dig, seg));
            end
            else if (dig === 8'b1111_1110)
                check_digit(elapsed_d % 10, "units");
            else if (dig === 8'b1111_1101)
                check_digit(elapsed_d / 10, "tens");
            else
                report_mismatch($sformatf("dig is %h, expected one of the two digits", dig));
        end
    end

endmodule

/* test/hatch_checker.sv */
// bound assertions on strobe width, stage encoding and active-low scan lines
`timescale 1ns/1ns

module hatch_checker #(
    parameter bit check_press = 1'b0,
    parameter bit check_tick = 1'b0,
    parameter bit check_stage = 1'b0,
    parameter bit check_scan = 1'b0
) (
    input logic       clk,
    input logic       sw7,
    input logic       press,
    input logic       tick,
    input logic [2:0] stage_code,
    input logic [7:0] scan_lines
);

    int fail_count = 0;

    if (check_press)
    begin : press_width
        single_press: assert property (@(posedge clk) disable iff (!sw7) press |=> !press)
        else
        begin
            $error("press strobe high for two cycles in a row");
            fail_count = fail_count + 1;
        end
    end

    if (check_tick)
    begin : tick_width
        single_tick: assert property (@(posedge clk) disable iff (!sw7) tick |=> !tick)
        else
        begin
            $error("tick strobe high for two cycles in a row");
            fail_count = fail_count + 1;
        end
    end

    // five stages, codes 0 to 4
    if (check_stage)
    begin : stage_code_range
        legal_stage: assert property (@(posedge clk) disable iff (!sw7) stage_code <= 3'd4)
        else
        begin
            $error("stage holds an illegal code");
            fail_count = fail_count + 1;
        end
    end

    // all lines off or exactly one driven low
    if (check_scan)
    begin : scan_lines_low
        scan_one_low: assert property (@(posedge clk) disable iff (!sw7)
            (scan_lines == 8'hff) || $onehot(~scan_lines))
        else
        begin
            $error("scan lines have more than one active bit");
            fail_count = fail_count + 1;
        end
    end

endmodule

bind hatch_fsm hatch_checker #(
    .check_tick (1'b1),
    .check_stage(1'b1)
) fsm_check (
    .clk       (clk),
    .sw7       (sw7),
    .press     (press),
    .tick      (tick),
    .stage_code(stage),
    .scan_lines(8'hff)
);

bind input_decode hatch_checker #(
    .check_press(1'b1)
) decode_check (
    .clk       (clk),
    .sw7       (sw7),
    .press     (press),
    .tick      (1'b0),
    .stage_code(3'd0),
    .scan_lines(8'hff)
);

bind seg_scan hatch_checker #(
    .check_scan(1'b1)
) seg_check (
    .clk       (clk),
    .sw7       (sw7),
    .press     (1'b0),
    .tick      (1'b0),
    .stage_code(stage),
    .scan_lines(dig)
);

bind matrix_scan hatch_checker #(
    .check_scan(1'b1)
) matrix_check (
    .clk       (clk),
    .sw7       (sw7),
    .press     (1'b0),
    .tick      (1'b0),
    .stage_code(stage),
    .scan_lines(row)
);

/* src/egg_hatch_top.sv */
// top level of the egg incubation game: decode, tick, FSM and display scanners
`timescale 1ns/1ns

module egg_hatch_top #(
    parameter int TICK_CYCLES = 50000000,
    parameter int DEBOUNCE_CYCLES = 500000,
    parameter int SCAN_CYCLES = 25000
) (
    input  logic       clk,
    input  logic       sw7,
    input  logic       btn0,
    input  logic       sw0,
    output logic       led0,
    output logic       led2,
    output logic [7:0] row,
    output logic [7:0] colg,
    output logic [7:0] colr,
    output logic [7:0] seg,
    output logic [7:0] dig
);

    import hatch_pkg::*;

    logic press;
    logic heat;
    logic tick;
    stage_t stage;
    logic [dev_width-1:0] dev_count;
    logic [sec_width-1:0] elapsed;

    input_decode #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_input_decode (
        .clk  (clk),
        .sw7  (sw7),
        .btn0 (btn0),
        .sw0  (sw0),
        .press(press),
        .heat (heat)
    );

    tick_gen #(
        .TICK_CYCLES(TICK_CYCLES)
    ) i_tick_gen (
        .clk (clk),
        .sw7 (sw7),
        .tick(tick)
    );

    hatch_fsm i_hatch_fsm (
        .clk      (clk),
        .sw7      (sw7),
        .press    (press),
        .tick     (tick),
        .heat     (heat),
        .stage    (stage),
        .dev_count(dev_count),
        .elapsed  (elapsed)
    );

    seg_scan #(
        .SCAN_CYCLES(SCAN_CYCLES)
    ) i_seg_scan (
        .clk    (clk),
        .sw7    (sw7),
        .stage  (stage),
        .elapsed(elapsed),
        .seg    (seg),
        .dig    (dig)
    );

    matrix_scan #(
        .SCAN_CYCLES(SCAN_CYCLES)
    ) i_matrix_scan (
        .clk      (clk),
        .sw7      (sw7),
        .stage    (stage),
        .dev_count(dev_count),
        .row      (row),
        .colr     (colr),
        .colg     (colg)
    );

    // result leds straight from the stage
    assign led0 = (stage == st_hatched);
    assign led2 = (stage == st_failed);

endmodule

/* src/matrix_scan.sv */
// 8x8 red/green matrix scanner with per-stage pictures
`timescale 1ns/1ns

module matrix_scan #(
    parameter int SCAN_CYCLES = 25000
) (
    input  logic                            clk,
    input  logic                            sw7,
    input  hatch_pkg::stage_t               stage,
    input  logic [hatch_pkg::dev_width-1:0] dev_count,
    output logic [7:0]                      row,
    output logic [7:0]                      colr,
    output logic [7:0]                      colg
);

    import hatch_pkg::*;

    localparam int slot_width = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

    logic [slot_width-1:0] slot_cnt;
    logic [2:0] row_idx;
    logic [2:0] crack_rows;
    logic [dev_width-1:0] fill;
    logic [7:0] red_bits;
    logic [7:0] green_bits;

    function automatic logic [7:0] egg_row(input logic [2:0] r);
        case (r)
            3'd0, 3'd7: return 8'b0011_1100;
            3'd1, 3'd6: return 8'b0100_0010;
            default: return 8'b1000_0001;
        endcase
    endfunction

    // inside of the shell
    function automatic logic [7:0] inner_row(input logic [2:0] r);
        case (r)
            3'd0, 3'd7: return 8'b0000_0000;
            3'd1, 3'd6: return 8'b0011_1100;
            default: return 8'b0111_1110;
        endcase
    endfunction

    function automatic logic [7:0] crack_row(input logic [2:0] r);
        case (r)
            3'd2: return 8'b0001_0000;
            3'd3: return 8'b0010_1000;
            3'd4: return 8'b0001_0100;
            3'd5: return 8'b0010_0000;
            default: return 8'b0000_0000;
        endcase
    endfunction

    function automatic logic [7:0] chick_row(input logic [2:0] r);
        case (r)
            3'd0: return 8'b0001_1000;
            3'd1: return 8'b0010_0100;
            3'd2: return 8'b0011_1100;
            3'd3: return 8'b0111_1110;
            3'd4: return 8'b1111_1111;
            3'd5: return 8'b0111_1110;
            3'd6: return 8'b0010_0100;
            default: return 8'b0110_0110;
        endcase
    endfunction

    // one crack row per four development steps
    assign crack_rows = 3'(dev_count >> 2);
    // green fills upward from the bottom once grown
    assign fill = (dev_count > dev_width'(dev_grown)) ? dev_count - dev_width'(dev_grown) : '0;

    always_comb
    begin
        red_bits = 8'h00;
        green_bits = 8'h00;
        case (stage)
            st_ready, st_incubate:
            begin
                red_bits = egg_row(row_idx);
                if ({1'b0, crack_rows} + 4'd2 > {1'b0, row_idx})
                    red_bits = red_bits | crack_row(row_idx);
            end
            st_growing:
            begin
                red_bits = egg_row(row_idx);
                if (fill + dev_width'(row_idx) >= dev_width'(7))
                    green_bits = inner_row(row_idx);
            end
            st_hatched:
                green_bits = chick_row(row_idx);
            st_failed:
                red_bits = (8'h01 << row_idx) | (8'h80 >> row_idx);
            default:
                red_bits = 8'h00;
        endcase
    end

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            slot_cnt <= '0;
            row_idx <= 3'd0;
        end
        else if (slot_cnt == slot_width'(SCAN_CYCLES - 1))
        begin
            slot_cnt <= '0;
            row_idx <= row_idx + 1'b1;
        end
        else
            slot_cnt <= slot_cnt + 1'b1;
    end

    // rows and columns are both active low
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            row <= 8'hff;
            colr <= 8'hff;
            colg <= 8'hff;
        end
        else
        begin
            row <= ~(8'h01 << row_idx);
            colr <= ~red_bits;
            colg <= ~green_bits;
        end
    end

endmodule

/* src/seg_scan.sv */
// two-digit seven-segment scanner for elapsed seconds
`timescale 1ns/1ns

module seg_scan #(
    parameter int SCAN_CYCLES = 25000
) (
    input  logic                            clk,
    input  logic                            sw7,
    input  hatch_pkg::stage_t               stage,
    input  logic [hatch_pkg::sec_width-1:0] elapsed,
    output logic [7:0]                      seg,
    output logic [7:0]                      dig
);

    import hatch_pkg::*;

    localparam int slot_width = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

    logic [slot_width-1:0] slot_cnt;
    logic sel_tens;
    logic [3:0] tens;
    logic [3:0] units;

    assign tens = 4'(elapsed / sec_width'(10));
    assign units = 4'(elapsed % sec_width'(10));

    // digit slot timer
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            slot_cnt <= '0;
            sel_tens <= 1'b0;
        end
        else if (slot_cnt == slot_width'(SCAN_CYCLES - 1))
        begin
            slot_cnt <= '0;
            sel_tens <= ~sel_tens;
        end
        else
            slot_cnt <= slot_cnt + 1'b1;
    end

    // blank while waiting, elapsed stays frozen in the end stages
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            seg <= 8'hff;
            dig <= 8'hff;
        end
        else if (stage == st_ready)
        begin
            seg <= 8'hff;
            dig <= 8'hff;
        end
        else
        begin
            dig <= sel_tens ? 8'b1111_1101 : 8'b1111_1110;
            seg <= seg_pattern(sel_tens ? tens : units);
        end
    end

endmodule

/* src/hatch_fsm.sv */
// stage FSM with elapsed, development, cold and tick-phase counters
`timescale 1ns/1ns

module hatch_fsm (
    input  logic                            clk,
    input  logic                            sw7,
    input  logic                            press,
    input  logic                            tick,
    input  logic                            heat,
    output hatch_pkg::stage_t               stage,
    output logic [hatch_pkg::dev_width-1:0] dev_count,
    output logic [hatch_pkg::sec_width-1:0] elapsed
);

    import hatch_pkg::*;

    localparam int cold_width = $clog2(cold_limit + 1);
    localparam logic [sec_width-1:0] sec_max = sec_width'(99);

    logic [cold_width-1:0] cold_count;
    logic phase;
    logic grow_en;
    logic [dev_width-1:0] dev_step;
    logic [cold_width-1:0] cold_step;
    logic [sec_width-1:0] elapsed_step;

    // counter values after the current tick
    always_comb
    begin
        // development on every second tick; heat only matters before growing
        grow_en = phase && (heat || stage == st_growing);
        dev_step = grow_en ? dev_count + 1'b1 : dev_count;
        cold_step = heat ? '0 : cold_count + 1'b1;
        elapsed_step = (elapsed == sec_max) ? elapsed : elapsed + 1'b1;
    end

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            stage <= st_ready;
            elapsed <= '0;
            dev_count <= '0;
            cold_count <= '0;
            phase <= 1'b0;
        end
        else
        begin
            case (stage)
                st_ready:
                begin
                    if (press)
                    begin
                        stage <= st_incubate;
                        elapsed <= '0;
                        dev_count <= '0;
                        cold_count <= '0;
                        phase <= 1'b0;
                    end
                end
                st_incubate:
                begin
                    if (tick)
                    begin
                        elapsed <= elapsed_step;
                        phase <= ~phase;
                        dev_count <= dev_step;
                        cold_count <= cold_step;
                        // failure wins over a threshold on the same tick
                        if (cold_step == cold_width'(cold_limit))
                            stage <= st_failed;
                        else if (dev_step == dev_width'(dev_grown))
                            stage <= st_growing;
                    end
                end
                st_growing:
                begin
                    if (tick)
                    begin
                        elapsed <= elapsed_step;
                        phase <= ~phase;
                        dev_count <= dev_step;
                        if (dev_step == dev_width'(dev_hatched))
                            stage <= st_hatched;
                    end
                end
                st_hatched, st_failed:
                begin
                    if (press)
                        stage <= st_ready;
                end
                default:
                    stage <= st_ready;
            endcase
        end
    end

endmodule

/* src/tick_gen.sv */
// one-second tick strobe from a reloading down counter
`timescale 1ns/1ns

module tick_gen #(
    parameter int TICK_CYCLES = 50000000
) (
    input  logic clk,
    input  logic sw7,
    output logic tick
);

    localparam int cnt_width = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [cnt_width-1:0] cnt;

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            cnt <= cnt_width'(TICK_CYCLES - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            // wrap marks one game second
            cnt <= cnt_width'(TICK_CYCLES - 1);
            tick <= 1'b1;
        end
        else
        begin
            cnt <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

/* src/input_decode.sv */
// button synchronizer and debounce with press strobe, heat switch synchronizer
`timescale 1ns/1ns

module input_decode #(
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic clk,
    input  logic sw7,
    input  logic btn0,
    input  logic sw0,
    output logic press,
    output logic heat
);

    localparam int cnt_width = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

    logic [1:0] btn_sync;
    logic [1:0] sw_sync;
    logic btn_level;
    logic [cnt_width-1:0] stable_cnt;

    // two-flop synchronizers
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            btn_sync <= 2'b00;
            sw_sync <= 2'b00;
        end
        else
        begin
            btn_sync <= {btn_sync[0], btn0};
            sw_sync <= {sw_sync[0], sw0};
        end
    end

    // new level accepted after DEBOUNCE_CYCLES differing cycles in a row
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            btn_level <= 1'b0;
            stable_cnt <= '0;
            press <= 1'b0;
        end
        else
        begin
            press <= 1'b0;
            if (btn_sync[1] == btn_level)
                stable_cnt <= '0;
            else if (stable_cnt == cnt_width'(DEBOUNCE_CYCLES - 1))
            begin
                stable_cnt <= '0;
                btn_level <= btn_sync[1];
                // strobe only on the rising level
                press <= btn_sync[1];
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

    assign heat = sw_sync[1];

endmodule

/* src/hatch_pkg.sv */
// stage encoding, counter widths, game thresholds and seven-segment digit patterns
package hatch_pkg;

    // game stages, st_ready follows reset
    typedef enum logic [2:0] {
        st_ready,
        st_incubate,
        st_growing,
        st_hatched,
        st_failed
    } stage_t;

    localparam int dev_width = 5;
    localparam int sec_width = 7;

    // development thresholds
    localparam int dev_grown = 10;
    localparam int dev_hatched = 16;

    // consecutive cold ticks before the egg is lost
    localparam int cold_limit = 5;

    // active-low segments {dp, g, f, e, d, c, b, a}, dp kept off
    function automatic logic [7:0] seg_pattern(input logic [3:0] digit);
        case (digit)
            4'd0: return 8'hc0;
            4'd1: return 8'hf9;
            4'd2: return 8'ha4;
            4'd3: return 8'hb0;
            4'd4: return 8'h99;
            4'd5: return 8'h92;
            4'd6: return 8'h82;
            4'd7: return 8'hf8;
            4'd8: return 8'h80;
            4'd9: return 8'h90;
            default: return 8'hff;
        endcase
    endfunction

endpackage
